// ==== tsc_cpu.f ====
+incdir+source
source/tsc_pkg.sv
source/tsc_ctrl_if.sv
source/tsc_alu.sv
source/tsc_register_file.sv
source/tsc_control.sv
source/tsc_datapath.sv
source/tsc_cpu.sv
dv/tsc_memory_model.sv
dv/tb_tsc_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_tsc_cpu -f tsc_cpu.f -o sim_tsc_cpu || exit 1
result=$(./obj_dir/sim_tsc_cpu)
echo "$result"
echo "$result" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1

// ==== dv/tb_tsc_cpu.sv ====
`timescale 1ns/1ns
`include "tsc_cfg.svh"

module tb_tsc_cpu;
	import tsc_pkg::*;

	localparam int T_RESET = 0;
	localparam int T_ALU = 1;
	localparam int T_MEM = 2;
	localparam int T_BRANCH = 3;
	localparam int T_HALT = 4;
	localparam int NUM_TESTS = 5;

	localparam reg_idx_t R0 = 2'd0;
	localparam reg_idx_t R1 = 2'd1;
	localparam reg_idx_t R2 = 2'd2;
	localparam reg_idx_t R3 = 2'd3;

	// Store uses 0x4010 + 5, load uses 0x4018 - 3
	localparam word_t STORE_ADDR = 16'h4015;

	logic clk = 1'b0;
	logic reset_n;
	logic readM;
	logic writeM;
	word_t address;
	wire word_t data;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	word_t lfsr = 16'd39;
	word_t asm_pc = '0;
	int prog_len = 0;
	int path_len = 0;
	word_t marker_val;
	word_t store_val;
	word_t last_exp = '0;
	word_t seen_port = '0;
	word_t exp_q [$];
	int exp_test_q [$];
	int errs [NUM_TESTS];
	bit reported [NUM_TESTS];
	bit halt_seen = 1'b0;
	int cur_test = T_ALU;

	always #20 clk = ~clk;

	tsc_cpu i_dut (
		.clk(clk),
		.reset_n(reset_n),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	tsc_memory_model i_memory (
		.clk(clk),
		.readM(readM),
		.writeM(writeM),
		.address(address),
		.data(data)
	);

	// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
	function automatic word_t random_bits(input int n);
		word_t v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	function automatic string test_name(input int t);
		case (t)
			T_RESET: return "reset";
			T_ALU: return "alu";
			T_MEM: return "memory";
			T_BRANCH: return "branch_jump";
			default: return "halt";
		endcase
	endfunction

	// Expected register function results
	function automatic word_t alu_ref(input func_t f, input word_t a, input word_t b);
		case (f)
			`INST_FUNC_ADD: return a + b;
			`INST_FUNC_SUB: return a - b;
			`INST_FUNC_AND: return a & b;
			`INST_FUNC_ORR: return a | b;
			`INST_FUNC_NOT: return ~a;
			`INST_FUNC_TCP: return 16'd0 - a;
			`INST_FUNC_SHL: return a << 1;
			default: return word_t'($signed(a) >>> 1);
		endcase
	endfunction

	// Instruction encoders
	function automatic word_t r_inst(input reg_idx_t rs, input reg_idx_t rt,
			input reg_idx_t rd, input func_t f);
		return {`RTYPE_OP, rs, rt, rd, f};
	endfunction

	function automatic word_t i_inst(input opcode_t op, input reg_idx_t rs,
			input reg_idx_t rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_inst(input opcode_t op, input word_t target);
		return {op, target[11:0]};
	endfunction

	function automatic word_t wwd(input reg_idx_t rs);
		return r_inst(rs, R0, R0, `INST_FUNC_WWD);
	endfunction

	task automatic emit(input word_t w, input bit on_path);
		i_memory.mem[asm_pc] = w;
		asm_pc = asm_pc + 16'd1;
		prog_len++;
		if (on_path) begin
			path_len++;
		end
	endtask

	// A repeated value leaves output_port unchanged, so nothing to expect
	task automatic expect_output(input word_t v, input int t);
		if (v != last_exp) begin
			exp_q.push_back(v);
			exp_test_q.push_back(t);
			last_exp = v;
		end
	endtask

	task automatic load_register(input reg_idx_t r, input word_t v);
		emit(i_inst(`LHI_OP, r, r, v[15:8]), 1'b1);
		emit(i_inst(`ORI_OP, r, r, v[7:0]), 1'b1);
	endtask

	task automatic marker();
		emit(i_inst(`ADI_OP, R3, R3, 8'd1), 1'b1);
		emit(wwd(R3), 1'b1);
		marker_val = marker_val + 16'd1;
		expect_output(marker_val, T_BRANCH);
	endtask

	task automatic branch_case(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
			input word_t va, input word_t vb);
		logic taken;
		case (op)
			`BNE_OP: taken = (va != vb);
			`BEQ_OP: taken = (va == vb);
			`BGZ_OP: taken = ($signed(va) > 0);
			default: taken = ($signed(va) < 0);
		endcase
		if (taken) begin
			emit(i_inst(op, rs, rt, 8'd1), 1'b1);
			emit(wwd(R1), 1'b0);
		end else begin
			// A wrong jump would skip the marker
			emit(i_inst(op, rs, rt, 8'd2), 1'b1);
		end
		marker();
	endtask

	task automatic build_program();
		word_t x;
		word_t y;
		word_t imm;
		word_t p;
		word_t n;
		word_t link;
		for (int k = 0; k < 2; k++) begin
			x = random_bits(16);
			y = random_bits(16);
			imm = random_bits(8);
			load_register(R0, x);
			load_register(R1, y);
			for (int f = 0; f < 8; f++) begin
				emit(r_inst(R0, R1, R3, func_t'(f)), 1'b1);
				emit(wwd(R3), 1'b1);
				expect_output(alu_ref(func_t'(f), x, y), T_ALU);
			end
			emit(i_inst(`ADI_OP, R0, R3, imm[7:0]), 1'b1);
			emit(wwd(R3), 1'b1);
			expect_output(x + {{8{imm[7]}}, imm[7:0]}, T_ALU);
			emit(i_inst(`ORI_OP, R0, R3, imm[7:0]), 1'b1);
			emit(wwd(R3), 1'b1);
			expect_output(x | {8'h00, imm[7:0]}, T_ALU);
			emit(i_inst(`LHI_OP, R0, R3, imm[7:0]), 1'b1);
			emit(wwd(R3), 1'b1);
			expect_output({imm[7:0], 8'h00}, T_ALU);
		end

		// Store then load back through a negative offset
		store_val = random_bits(16);
		load_register(R0, 16'h4010);
		load_register(R1, store_val);
		emit(i_inst(`SWD_OP, R0, R1, 8'h05), 1'b1);
		load_register(R2, 16'h4018);
		emit(i_inst(`LWD_OP, R2, R3, 8'hFD), 1'b1);
		emit(wwd(R3), 1'b1);
		expect_output(store_val, T_MEM);

		p = (random_bits(16) & 16'h7FFF) | 16'h0001;
		n = random_bits(16) | 16'h8000;
		load_register(R0, p);
		load_register(R1, n);
		emit(i_inst(`LHI_OP, R3, R3, 8'h5A), 1'b1);
		marker_val = 16'h5A00;
		branch_case(`BNE_OP, R0, R1, p, n);
		branch_case(`BNE_OP, R0, R0, p, p);
		branch_case(`BEQ_OP, R0, R0, p, p);
		branch_case(`BEQ_OP, R0, R1, p, n);
		branch_case(`BGZ_OP, R0, R0, p, p);
		branch_case(`BGZ_OP, R1, R1, n, n);
		branch_case(`BLZ_OP, R1, R1, n, n);
		branch_case(`BLZ_OP, R0, R0, p, p);

		emit(j_inst(`JMP_OP, asm_pc + 16'd2), 1'b1);
		emit(wwd(R1), 1'b0);
		marker();
		link = asm_pc + 16'd1;
		emit(j_inst(`JAL_OP, asm_pc + 16'd2), 1'b1);
		emit(wwd(R1), 1'b0);
		emit(wwd(R2), 1'b1);
		expect_output(link, T_BRANCH);
		marker();
		// Target sits after LHI, ORI, JPR and the skipped word
		load_register(R0, asm_pc + 16'd4);
		emit(r_inst(R0, R0, R0, `INST_FUNC_JPR), 1'b1);
		emit(wwd(R1), 1'b0);
		marker();
		load_register(R0, asm_pc + 16'd4);
		link = asm_pc + 16'd1;
		emit(r_inst(R0, R0, R0, `INST_FUNC_JRL), 1'b1);
		emit(wwd(R1), 1'b0);
		emit(wwd(R2), 1'b1);
		expect_output(link, T_BRANCH);
		marker();

		emit(r_inst(R0, R0, R0, `INST_FUNC_HLT), 1'b1);
		// Never reached
		emit(wwd(R1), 1'b0);
	endtask

	task automatic check_value(input int t, input word_t exp, input word_t act);
		assert (act == exp) else begin
			$display("CHECK FAILED %s: expected %h, actual %h", test_name(t), exp, act);
			errs[t]++;
		end
	endtask

	task automatic report_test(input int t);
		if (!reported[t]) begin
			reported[t] = 1'b1;
			$display("%s: %s with %0d errors", test_name(t),
				(errs[t] == 0) ? "passed" : "failed", errs[t]);
		end
	endtask

	// Each new output_port value against the queue of expected values
	always @(negedge clk) begin
		int t;
		if (reset_n && output_port != seen_port) begin
			seen_port = output_port;
			if (exp_q.size() == 0) begin
				$display("output_port changed to %h when no output was expected", output_port);
				errs[cur_test]++;
			end else begin
				t = exp_test_q.pop_front();
				cur_test = t;
				check_value(t, exp_q.pop_front(), output_port);
				if (t == T_MEM) begin
					check_value(T_MEM, store_val, i_memory.mem[STORE_ADDR]);
				end
				if (exp_test_q.size() == 0 || exp_test_q[0] != t) begin
					report_test(t);
				end
			end
		end
	end

	// Halted state holds and fetches stop
	always @(negedge clk) begin
		if (is_halted) begin
			halt_seen = 1'b1;
		end
		if (halt_seen) begin
			assert (is_halted) else begin
				$display("is_halted fell after the CPU halted");
				errs[T_HALT]++;
			end
			assert (!readM) else begin
				$display("readM is high while the CPU is halted");
				errs[T_HALT]++;
			end
		end
	end

	initial begin
		int limit;
		int cycles;
		int reads_at_halt;
		int failed;
		int total;
		reset_n = 1'b0;
		failed = 0;
		total = 0;
		build_program();
		limit = 5 * prog_len + 20;
		repeat (3) @(posedge clk);
		reset_n <= 1'b1;

		@(negedge clk);
		check_value(T_RESET, '0, num_inst);
		check_value(T_RESET, '0, output_port);
		check_value(T_RESET, '0, word_t'(is_halted));
		check_value(T_RESET, 16'd1, word_t'(readM));
		check_value(T_RESET, '0, word_t'(writeM));
		check_value(T_RESET, '0, address);
		report_test(T_RESET);

		cycles = 0;
		while (!is_halted && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!is_halted) begin
			$display("Timeout: the CPU did not halt within %0d cycles", limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			reads_at_halt = i_memory.read_count;
			check_value(T_HALT, word_t'(path_len), num_inst);
			repeat (8) @(negedge clk);
			assert (i_memory.read_count == reads_at_halt) else begin
				$display("Memory was read after the CPU halted");
				errs[T_HALT]++;
			end
			if (exp_q.size() != 0) begin
				$display("%0d expected output values never appeared", exp_q.size());
				errs[exp_test_q[0]]++;
			end
			for (int t = 0; t < NUM_TESTS; t++) begin
				report_test(t);
				if (errs[t] != 0) begin
					failed++;
				end
				total += errs[t];
			end
			$display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, failed, total);
			if (failed == 0) begin
				$display("TEST RESULT: PASS");
			end else begin
				$display("TEST RESULT: FAIL");
			end
			$finish;
		end
	end

endmodule

// ==== dv/tsc_memory_model.sv ====
`timescale 1ns/1ns
`include "tsc_cfg.svh"

module tsc_memory_model (
	input logic clk,
	input logic readM,
	input logic writeM,
	input tsc_pkg::word_t address,
	inout tsc_pkg::word_t data
);
	import tsc_pkg::*;

	// One word for every address of the 16-bit space
	word_t mem [2**`WORD_SIZE];

	// Read count for spotting fetches after halt
	int read_count = 0;

	// Read answers in the same cycle
	assign data = readM ? mem[address] : 'z;

	always @(posedge clk) begin
		if (writeM) begin
			mem[address] <= data;
		end
		if (readM) begin
			read_count <= read_count + 1;
		end
	end

endmodule

// ==== source/tsc_cpu.sv ====
`timescale 1ns/1ns

module tsc_cpu (
	input logic clk,
	input logic reset_n,
	output logic readM,
	output logic writeM,
	output tsc_pkg::word_t address,
	inout tsc_pkg::word_t data,
	output tsc_pkg::word_t num_inst,
	output tsc_pkg::word_t output_port,
	output logic is_halted
);

	tsc_ctrl_if ctrl ();

	tsc_control i_control (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl.control)
	);

	tsc_datapath i_datapath (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl.datapath),
		.address(address),
		.data(data),
		.num_inst(num_inst),
		.output_port(output_port)
	);

	// Memory strobes and status straight from control
	assign readM = ctrl.mem_read;
	assign writeM = ctrl.mem_write;
	assign is_halted = ctrl.halt;

endmodule

// ==== source/tsc_datapath.sv ====
`timescale 1ns/1ns
`include "tsc_cfg.svh"

module tsc_datapath (
	input logic clk,
	input logic reset_n,
	tsc_ctrl_if.datapath ctrl,
	output tsc_pkg::word_t address,
	inout tsc_pkg::word_t data,
	output tsc_pkg::word_t num_inst,
	output tsc_pkg::word_t output_port
);
	import tsc_pkg::*;

	word_t pc;
	word_t pc_plus1;
	word_t pc_next;
	word_t ir;
	word_t a_reg;
	word_t b_reg;
	word_t mdr;
	word_t read_out1;
	word_t read_out2;
	word_t imm_ext;
	word_t alu_b;
	word_t alu_result;
	word_t write_data;
	word_t branch_target;
	word_t jump_target;
	reg_idx_t write_reg;
	logic is_rtype;
	logic wwd_retire;

	// Instruction register fields
	assign ctrl.opcode = ir[`WORD_SIZE-1 -: 4];
	assign ctrl.func = ir[5:0];
	assign is_rtype = (ctrl.opcode == `RTYPE_OP);

	tsc_register_file i_register_file (
		.clk(clk),
		.reset_n(reset_n),
		.read1(ir[11:10]),
		.read2(ir[9:8]),
		.write_reg(write_reg),
		.write_data(write_data),
		.reg_write(ctrl.reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	// ORI zero-extends, LHI fills the upper byte, the rest sign-extend
	always_comb begin
		case (ctrl.opcode)
			`ORI_OP: imm_ext = {8'h00, ir[7:0]};
			`LHI_OP: imm_ext = {ir[7:0], 8'h00};
			default: imm_ext = {{8{ir[7]}}, ir[7:0]};
		endcase
	end

	assign alu_b = ctrl.alu_src ? imm_ext : b_reg;

	tsc_alu i_alu (
		.a(a_reg),
		.b(alu_b),
		.opcode(ctrl.opcode),
		.func(ctrl.func),
		.result(alu_result)
	);

	always_comb begin
		case (ctrl.opcode)
			`BNE_OP: ctrl.bcond = (a_reg != b_reg);
			`BEQ_OP: ctrl.bcond = (a_reg == b_reg);
			`BGZ_OP: ctrl.bcond = ($signed(a_reg) > 0);
			`BLZ_OP: ctrl.bcond = ($signed(a_reg) < 0);
			default: ctrl.bcond = 1'b0;
		endcase
	end

	// Next PC candidates
	assign pc_plus1 = pc + word_t'(1);
	assign branch_target = pc_plus1 + imm_ext;
	assign jump_target = {pc[`WORD_SIZE-1 -: 4], ir[11:0]};

	always_comb begin
		case (ctrl.pc_src)
			PC_BRANCH: pc_next = branch_target;
			PC_JUMP: pc_next = jump_target;
			PC_REG: pc_next = a_reg;
			default: pc_next = pc_plus1;
		endcase
	end

	// Write-back target and value
	assign write_reg = ctrl.pc_to_reg ? LINK_REG : (is_rtype ? ir[7:6] : ir[9:8]);
	assign write_data = ctrl.pc_to_reg ? pc_plus1 : (ctrl.mem_to_reg ? mdr : alu_result);

	// Memory port
	assign address = ctrl.i_or_d ? alu_result : pc;
	assign data = ctrl.mem_write ? b_reg : 'z;

	assign wwd_retire = ctrl.inst_done && is_rtype && (ctrl.func == `INST_FUNC_WWD);

	always_ff @(posedge clk) begin
		if (ctrl.ir_write) begin
			ir <= data;
		end
		if (ctrl.operand_latch) begin
			a_reg <= read_out1;
			b_reg <= read_out2;
		end
		// Load data arrives in the MEM cycle
		if (ctrl.mem_read && ctrl.i_or_d) begin
			mdr <= data;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			num_inst <= '0;
			output_port <= '0;
		end else begin
			if (ctrl.pc_write) begin
				pc <= pc_next;
			end
			if (ctrl.inst_done) begin
				num_inst <= num_inst + word_t'(1);
			end
			if (wwd_retire) begin
				output_port <= a_reg;
			end
		end
	end

endmodule

// ==== source/tsc_control.sv ====
`timescale 1ns/1ns
`include "tsc_cfg.svh"

module tsc_control (
	input logic clk,
	input logic reset_n,
	tsc_ctrl_if.control ctrl
);
	import tsc_pkg::*;

	cpu_state_t state;
	cpu_state_t next_state;

	logic is_rtype;
	logic is_rtype_alu;
	logic is_imm;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic is_jump;
	logic is_reg_jump;
	logic is_link;
	logic is_halt;

	// Instruction classes
	assign is_rtype = (ctrl.opcode == `RTYPE_OP);
	assign is_rtype_alu = is_rtype && (ctrl.func <= `INST_FUNC_SHR);
	assign is_imm = (ctrl.opcode == `ADI_OP) || (ctrl.opcode == `ORI_OP) ||
		(ctrl.opcode == `LHI_OP);
	assign is_load = (ctrl.opcode == `LWD_OP);
	assign is_store = (ctrl.opcode == `SWD_OP);
	assign is_branch = (ctrl.opcode <= `BLZ_OP);
	assign is_jump = (ctrl.opcode == `JMP_OP) || (ctrl.opcode == `JAL_OP);
	assign is_reg_jump = is_rtype &&
		((ctrl.func == `INST_FUNC_JPR) || (ctrl.func == `INST_FUNC_JRL));
	assign is_link = (ctrl.opcode == `JAL_OP) || (is_rtype && ctrl.func == `INST_FUNC_JRL);
	assign is_halt = is_rtype && (ctrl.func == `INST_FUNC_HLT);

	// Immediate operand for I-type and memory instructions in every state
	assign ctrl.alu_src = is_imm || is_load || is_store;
	assign ctrl.halt = (state == ST_HALT);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ST_IF;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		ctrl.pc_write = 1'b0;
		ctrl.ir_write = 1'b0;
		ctrl.i_or_d = 1'b0;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.operand_latch = 1'b0;
		ctrl.mem_to_reg = 1'b0;
		ctrl.pc_to_reg = 1'b0;
		ctrl.pc_src = PC_SEQ;
		ctrl.inst_done = 1'b0;

		case (state)
			ST_IF: begin
				ctrl.mem_read = 1'b1;
				ctrl.ir_write = 1'b1;
				next_state = ST_ID;
			end
			ST_ID: begin
				ctrl.operand_latch = 1'b1;
				next_state = ST_EX;
			end
			ST_EX: begin
				if (is_load || is_store) begin
					next_state = ST_MEM;
				end else if (is_imm || is_rtype_alu) begin
					next_state = ST_WB;
				end else if (is_halt) begin
					ctrl.inst_done = 1'b1;
					next_state = ST_HALT;
				end else begin
					// Branches, jumps, WWD and unknown codes retire here
					ctrl.pc_write = 1'b1;
					ctrl.inst_done = 1'b1;
					next_state = ST_IF;
					if (is_branch) begin
						ctrl.pc_src = ctrl.bcond ? PC_BRANCH : PC_SEQ;
					end else if (is_jump) begin
						ctrl.pc_src = PC_JUMP;
					end else if (is_reg_jump) begin
						ctrl.pc_src = PC_REG;
					end
					if (is_link) begin
						ctrl.reg_write = 1'b1;
						ctrl.pc_to_reg = 1'b1;
					end
				end
			end
			ST_MEM: begin
				ctrl.i_or_d = 1'b1;
				if (is_load) begin
					ctrl.mem_read = 1'b1;
					next_state = ST_WB;
				end else begin
					ctrl.mem_write = 1'b1;
					ctrl.pc_write = 1'b1;
					ctrl.inst_done = 1'b1;
					next_state = ST_IF;
				end
			end
			ST_WB: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = is_load;
				ctrl.pc_write = 1'b1;
				ctrl.inst_done = 1'b1;
				next_state = ST_IF;
			end
			ST_HALT: begin
				// Only reset leaves this state
				next_state = ST_HALT;
			end
			default: begin
				next_state = ST_IF;
			end
		endcase
	end

endmodule

// ==== source/tsc_register_file.sv ====
`timescale 1ns/1ns
`include "tsc_cfg.svh"

module tsc_register_file (
	input logic clk,
	input logic reset_n,
	input tsc_pkg::reg_idx_t read1,
	input tsc_pkg::reg_idx_t read2,
	input tsc_pkg::reg_idx_t write_reg,
	input tsc_pkg::word_t write_data,
	input logic reg_write,
	output tsc_pkg::word_t read_out1,
	output tsc_pkg::word_t read_out2
);
	import tsc_pkg::*;

	word_t regs [`NUM_REGS];

	// Reads are combinational
	assign read_out1 = regs[read1];
	assign read_out2 = regs[read2];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

endmodule

// ==== source/tsc_alu.sv ====
`timescale 1ns/1ns
`include "tsc_cfg.svh"

module tsc_alu (
	input tsc_pkg::word_t a,
	input tsc_pkg::word_t b,
	input tsc_pkg::opcode_t opcode,
	input tsc_pkg::func_t func,
	output tsc_pkg::word_t result
);
	import tsc_pkg::*;

	alu_op_t op;

	// Operation from opcode and function code
	always_comb begin
		case (opcode)
			`ADI_OP, `LWD_OP, `SWD_OP: op = ALU_ADD;
			`ORI_OP: op = ALU_ORR;
			`RTYPE_OP: begin
				case (func)
					`INST_FUNC_ADD: op = ALU_ADD;
					`INST_FUNC_SUB: op = ALU_SUB;
					`INST_FUNC_AND: op = ALU_AND;
					`INST_FUNC_ORR: op = ALU_ORR;
					`INST_FUNC_NOT: op = ALU_NOT;
					`INST_FUNC_TCP: op = ALU_TCP;
					`INST_FUNC_SHL: op = ALU_SHL;
					`INST_FUNC_SHR: op = ALU_SHR;
					default: op = ALU_PASS_B;
				endcase
			end
			// LHI operand already sits in the upper byte
			default: op = ALU_PASS_B;
		endcase
	end

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_ORR: result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + word_t'(1);
			ALU_SHL: result = {a[`WORD_SIZE-2:0], 1'b0};
			// Arithmetic, sign bit repeats
			ALU_SHR: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};
			default: result = b;
		endcase
	end

endmodule

// ==== source/tsc_ctrl_if.sv ====
`timescale 1ns/1ns

interface tsc_ctrl_if;
	import tsc_pkg::*;

	// Strobes and selectors, valid in the state that raises them
	logic pc_write;
	logic ir_write;
	logic i_or_d;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic operand_latch;
	logic alu_src;
	logic mem_to_reg;
	logic pc_to_reg;
	logic [1:0] pc_src;
	logic inst_done;
	logic halt;

	// Back from the instruction register
	opcode_t opcode;
	func_t func;
	logic bcond;

	modport control (
		output pc_write, ir_write, i_or_d, mem_read, mem_write, reg_write, operand_latch,
		output alu_src, mem_to_reg, pc_to_reg, pc_src, inst_done, halt,
		input opcode, func, bcond
	);

	modport datapath (
		input pc_write, ir_write, i_or_d, mem_read, mem_write, reg_write, operand_latch,
		input alu_src, mem_to_reg, pc_to_reg, pc_src, inst_done,
		output opcode, func, bcond
	);

endinterface

// ==== source/tsc_pkg.sv ====
`include "tsc_cfg.svh"

package tsc_pkg;

	// Data and address word
	typedef logic [`WORD_SIZE-1:0] word_t;

	// Register number
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	// Instruction fields
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_ORR,
		ALU_NOT,
		ALU_TCP,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		ST_IF,
		ST_ID,
		ST_EX,
		ST_MEM,
		ST_WB,
		ST_HALT
	} cpu_state_t;

	// Next PC selection
	localparam logic [1:0] PC_SEQ    = 2'd0;
	localparam logic [1:0] PC_BRANCH = 2'd1;
	localparam logic [1:0] PC_JUMP   = 2'd2;
	localparam logic [1:0] PC_REG    = 2'd3;

	// JAL and JRL put the return address here
	localparam reg_idx_t LINK_REG = 2'd2;

endpackage

// ==== source/tsc_cfg.svh ====
`ifndef TSC_CFG_SVH
`define TSC_CFG_SVH

`define WORD_SIZE 16
`define NUM_REGS  4

// Opcode numbers
`define BNE_OP   4'd0
`define BEQ_OP   4'd1
`define BGZ_OP   4'd2
`define BLZ_OP   4'd3
`define ADI_OP   4'd4
`define ORI_OP   4'd5
`define LHI_OP   4'd6
`define LWD_OP   4'd7
`define SWD_OP   4'd8
`define JMP_OP   4'd9
`define JAL_OP   4'd10
`define RTYPE_OP 4'd15

// Function codes of the register class
`define INST_FUNC_ADD 6'd0
`define INST_FUNC_SUB 6'd1
`define INST_FUNC_AND 6'd2
`define INST_FUNC_ORR 6'd3
`define INST_FUNC_NOT 6'd4
`define INST_FUNC_TCP 6'd5
`define INST_FUNC_SHL 6'd6
`define INST_FUNC_SHR 6'd7
`define INST_FUNC_JPR 6'd25
`define INST_FUNC_JRL 6'd26
`define INST_FUNC_WWD 6'd28
`define INST_FUNC_HLT 6'd29

`endif
